//--- mem_req_ctrl.f
source/mem_ctrl_pkg.sv
source/client_bank_if.sv
source/client_req_ctrl.sv
source/bank_port_mux.sv
source/mem_req_ctrl.sv
sim/tb_clk_gen.sv
sim/tb_mem_req_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

# build the testbench and the design into one executable
verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module tb_mem_req_ctrl -f mem_req_ctrl.f -o tb_mem_req_ctrl

output=$(./obj_dir/tb_mem_req_ctrl)
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
	exit 0
else
	exit 1
fi

//--- sim/tb_mem_req_ctrl.sv
`timescale 1ns/1ps

module tb_mem_req_ctrl
	import mem_ctrl_pkg::*;
();

	localparam int num_clients = 4;

	logic                                  clk;
	logic                                  rst_n;
	logic [num_clients-1:0]                read_req;
	logic [num_clients-1:0]                write_req;
	mem_addr_t [num_clients-1:0]           read_addr;
	mem_addr_t [num_clients-1:0]           write_addr;
	logic [num_clients-1:0][size_w-1:0]    read_size;
	logic [num_clients-1:0][size_w-1:0]    write_size;
	line_t [num_clients-1:0]               write_data;
	logic [num_clients-1:0]                read_valid;
	logic [num_clients-1:0]                write_ack;
	line_t [num_clients-1:0]               read_data;
	logic [num_banks-1:0][num_clients-1:0] req;
	logic [num_banks-1:0][num_clients-1:0] gnt;
	line_t [num_banks-1:0]                 bank_rdata;
	line_t [num_banks-1:0]                 bank_wdata;
	logic [num_banks-1:0]                  bank_cs;
	logic [num_banks-1:0]                  bank_read;
	logic [num_banks-1:0]                  bank_write;
	logic [num_banks-1:0]                  bank_mask_en;
	mem_addr_t [num_banks-1:0]             bank_addr;
	mask_t [num_banks-1:0]                 bank_mask;

	line_t      sram [num_banks][1024];     // one array per bank, indexed by row
	logic [7:0] ref_mem [0:(1<<addr_w)-1];  // byte image of the whole address space
	int         seed = 32'hc3f46033;
	int         errors;                     // written by the compare process only
	int         err_mark;
	int         tests;
	int         failed;
	int         issued;                     // requests posted so far, sets the timeout
	int         cycles;
	int         rd_count [num_clients];     // responses seen per client
	int         wr_count [num_clients];
	int         rd_expect [num_clients];    // responses owed per client
	int         wr_expect [num_clients];
	logic       expect_quiet;               // no control output may be high
	logic       expect_full;                // every write must be a full line

	tb_clk_gen u_tb_clk_gen (.clk(clk), .rst_n(rst_n));

	mem_req_ctrl #(.num_clients(num_clients)) u_mem_req_ctrl (.*);

	// ------------------------------------------------------------------------
	// arbiter and sram models
	// ------------------------------------------------------------------------
	always_comb begin
		logic found;

		gnt = '0;
		for (int b = 0; b < num_banks; b++) begin
			found = 1'b0;
			for (int c = 0; c < num_clients; c++) begin
				if (req[b][c] && !found) begin // lowest client number wins
					gnt[b][c] = 1'b1;
					found     = 1'b1;
				end
			end
		end
	end

	always @(posedge clk) begin
		for (int b = 0; b < num_banks; b++) begin
			if (bank_cs[b] && bank_read[b])
				bank_rdata[b] <= sram[b][bank_addr[b][14:5]]; // data shows up next cycle
			if (bank_cs[b] && bank_write[b]) begin
				if (bank_mask_en[b])
					sram[b][bank_addr[b][14:5]] <= (sram[b][bank_addr[b][14:5]] & ~bank_mask[b])
						| (bank_wdata[b] & bank_mask[b]);
				else
					sram[b][bank_addr[b][14:5]] <= bank_wdata[b];
			end
		end
	end

	// every byte starts from a value that mixes all of its address bits
	function automatic logic [7:0] fill_byte(input mem_addr_t a);
		return a[7:0] ^ a[15:8] ^ {5'b00000, a[18:16]} ^ 8'h3c;
	endfunction

	initial begin
		mem_addr_t  ma;
		logic [7:0] fb;

		bank_rdata = '0;
		for (int a = 0; a < (1 << addr_w); a++) begin
			ma = mem_addr_t'(a);
			fb = fill_byte(ma);
			ref_mem[ma] = fb;
			sram[{ma[18:16], ma[5]}][ma[15:6]][{ma[4:0], 3'b000} +: 8] = fb;
		end
	end

	// ------------------------------------------------------------------------
	// reference model and checking
	// ------------------------------------------------------------------------

	// expected read bytes, packed from byte zero, zero past the size
	function automatic line_t ref_read(input mem_addr_t addr, input int size);
		line_t r;

		r = '0;
		for (int i = 0; i < size; i++)
			r[i*8 +: 8] = ref_mem[mem_addr_t'(int'(addr) + i)]; // wraps at the top
		return r;
	endfunction

	task automatic check_eq(input string name, input line_t got, input line_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// outputs are looked at in the middle of the cycle, well away from any edge
	always @(negedge clk) begin
		line_t got;

		for (int c = 0; c < num_clients; c++) begin
			if (read_valid[c]) begin
				if (!read_req[c]) begin
					$display("client %0d gave read_valid with no read pending", c);
					errors++;
				end
				got = '0;
				for (int i = 0; i < int'(read_size[c]); i++)
					got[i*8 +: 8] = read_data[c][i*8 +: 8]; // bytes past the size are free
				check_eq($sformatf("read_data[%0d]", c), got,
					ref_read(read_addr[c], int'(read_size[c])));
				rd_count[c]++;
			end
			if (write_ack[c]) begin
				if (!write_req[c]) begin
					$display("client %0d gave write_ack with no write pending", c);
					errors++;
				end
				if (read_req[c]) begin
					$display("client %0d finished its write before its pending read", c);
					errors++;
				end
				for (int i = 0; i < int'(write_size[c]); i++)
					ref_mem[mem_addr_t'(int'(write_addr[c]) + i)] = write_data[c][i*8 +: 8];
				wr_count[c]++;
			end
		end
		if (!rst_n || expect_quiet) begin
			check_eq("req", line_t'(req), '0);
			check_eq("bank_cs", line_t'(bank_cs), '0);
			check_eq("bank_read", line_t'(bank_read), '0);
			check_eq("bank_write", line_t'(bank_write), '0);
			check_eq("bank_mask_en", line_t'(bank_mask_en), '0);
			check_eq("read_valid", line_t'(read_valid), '0);
			check_eq("write_ack", line_t'(write_ack), '0);
		end
		for (int b = 0; b < num_banks; b++) begin
			// region and bank bit sit on top of the sram address
			if (bank_cs[b])
				check_eq($sformatf("bank_addr[%0d] bank field", b),
					line_t'(bank_addr[b][18:15]), line_t'(b));
			if (expect_full && bank_write[b])
				check_eq($sformatf("bank_mask_en[%0d]", b), line_t'(bank_mask_en[b]), '0);
		end
	end

	// the limit grows with every request that goes out
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > 200 * issued + 100) begin
			$display("timeout, the DUT stopped answering after %0d cycles", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	function automatic int byte_addr(input int region, input int row, input int bank,
		input int offset);
		return region * 65536 + row * 64 + bank * 32 + offset;
	endfunction

	function automatic line_t rand_line();
		line_t d;

		for (int k = 0; k < 8; k++)
			d[k*32 +: 32] = $random(seed);
		return d;
	endfunction

	task automatic post_read(input int c, input int addr, input int size);
		read_req[c]  = 1'b1;
		read_addr[c] = mem_addr_t'(addr);
		read_size[c] = size_w'(size);
		rd_expect[c]++;
		issued++;
	endtask

	task automatic post_write(input int c, input int addr, input int size, input line_t data);
		write_req[c]  = 1'b1;
		write_addr[c] = mem_addr_t'(addr);
		write_size[c] = size_w'(size);
		write_data[c] = data;
		wr_expect[c]++;
		issued++;
	endtask

	// a request drops one ns after the edge that closes its response cycle
	task automatic wait_done();
		logic busy;

		busy = 1'b1;
		while (busy) begin
			@(posedge clk);
			#1;
			busy = 1'b0;
			for (int c = 0; c < num_clients; c++) begin
				if (rd_count[c] == rd_expect[c])
					read_req[c] = 1'b0;
				else
					busy = 1'b1;
				if (wr_count[c] == wr_expect[c])
					write_req[c] = 1'b0;
				else
					busy = 1'b1;
			end
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors != err_mark)
			failed++;
		$display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "failed");
		err_mark = errors;
	endtask

	initial begin
		int base;

		read_req     = '0;
		write_req    = '0;
		read_addr    = '0;
		write_addr   = '0;
		read_size    = '0;
		write_size   = '0;
		write_data   = '0;
		expect_quiet = 1'b1;
		expect_full  = 1'b0;
		@(posedge rst_n);
		repeat (6) @(posedge clk);
		#1;
		expect_quiet = 1'b0;
		finish_test("reset");

		expect_full = 1'b1; // aligned 32-byte writes in four regions
		for (int c = 0; c < num_clients; c++)
			post_write(c, byte_addr(2 * c + 1, 17 + c, c % 2, 0), 32, rand_line());
		wait_done();
		expect_full = 1'b0;
		for (int c = 0; c < num_clients; c++)
			post_read(c, byte_addr(2 * c + 1, 17 + c, c % 2, 0), 32);
		wait_done();
		finish_test("aligned lines");

		// two-line accesses, one of them leaving the last line of a region
		post_write(0, byte_addr(1, 40, 0, 20), 30, rand_line());
		post_write(1, byte_addr(2, 1023, 1, 7), 32, rand_line());
		post_write(2, byte_addr(6, 5, 1, 31), 2, rand_line());
		wait_done();
		post_read(0, byte_addr(1, 40, 0, 18), 32);
		post_read(1, byte_addr(2, 1023, 1, 3), 32);
		post_read(2, byte_addr(6, 5, 1, 30), 3);
		post_read(3, byte_addr(7, 1023, 1, 16), 32); // wraps to address zero
		wait_done();
		finish_test("spanning lines");

		post_write(0, byte_addr(4, 9, 0, 0), 32, rand_line());
		wait_done();
		post_write(0, byte_addr(4, 9, 0, 5), 3, rand_line());
		post_write(1, byte_addr(4, 9, 0, 12), 1, rand_line());
		post_write(2, byte_addr(4, 9, 0, 30), 2, rand_line());
		wait_done();
		post_read(3, byte_addr(4, 9, 0, 0), 32); // untouched bytes keep the full write
		wait_done();
		finish_test("partial writes");

		// all clients fight over banks 0 and 1, client 0 has a read and a write
		post_read(0, byte_addr(0, 10, 0, 4), 20);
		post_write(0, byte_addr(0, 10, 0, 0), 32, rand_line());
		post_write(1, byte_addr(0, 11, 0, 16), 32, rand_line());
		post_read(2, byte_addr(0, 12, 0, 0), 32);
		post_write(3, byte_addr(0, 13, 1, 8), 32, rand_line());
		wait_done();
		post_read(0, byte_addr(0, 10, 0, 0), 32);
		post_read(1, byte_addr(0, 11, 0, 16), 32);
		post_read(2, byte_addr(0, 13, 1, 8), 32);
		post_read(3, byte_addr(0, 10, 0, 4), 20);
		wait_done();
		finish_test("bank collisions");

		// clients sit two regions apart, so a spill never meets another client
		for (int n = 0; n < 50; n++) begin
			base = $random(seed) & 7;
			for (int c = 0; c < num_clients; c++) begin
				if ($random(seed) & 1)
					post_write(c, ((base + 2 * c) % 8) * 65536 + ($random(seed) & 65535),
						($random(seed) & 31) + 1, rand_line());
				else
					post_read(c, ((base + 2 * c) % 8) * 65536 + ($random(seed) & 65535),
						($random(seed) & 31) + 1);
			end
			wait_done();
		end
		finish_test("random mix");

		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps

// free-running clock and a power-on reset for the testbench
module tb_clk_gen #(
	parameter int period       = 4, // clock period in ns
	parameter int reset_cycles = 4  // rising edges seen with rst_n low
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// released just after an edge so the release never meets a clock edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

//--- source/mem_req_ctrl.sv
`timescale 1ns/1ps

module mem_req_ctrl
	import mem_ctrl_pkg::*;
#(
	parameter int num_clients = 4
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	// client read side
	input  logic [num_clients-1:0]                read_req,
	input  mem_addr_t [num_clients-1:0]           read_addr,
	input  logic [num_clients-1:0][size_w-1:0]    read_size,
	output logic [num_clients-1:0]                read_valid,
	output line_t [num_clients-1:0]               read_data,
	// client write side
	input  logic [num_clients-1:0]                write_req,
	input  mem_addr_t [num_clients-1:0]           write_addr,
	input  logic [num_clients-1:0][size_w-1:0]    write_size,
	input  line_t [num_clients-1:0]               write_data,
	output logic [num_clients-1:0]                write_ack,
	// external arbiter, both matrices are [bank][client]
	output logic [num_banks-1:0][num_clients-1:0] req,
	input  logic [num_banks-1:0][num_clients-1:0] gnt,
	// sram banks
	input  line_t [num_banks-1:0]                 bank_rdata,
	output logic [num_banks-1:0]                  bank_cs,
	output logic [num_banks-1:0]                  bank_read,
	output logic [num_banks-1:0]                  bank_write,
	output mem_addr_t [num_banks-1:0]             bank_addr,
	output line_t [num_banks-1:0]                 bank_wdata,
	output logic [num_banks-1:0]                  bank_mask_en,
	output mask_t [num_banks-1:0]                 bank_mask
);

	client_bank_if bank_if [num_clients] (); // one command bundle per client

	// ------------------------------------------------------------------------
	// client controllers
	// ------------------------------------------------------------------------
	for (genvar i = 0; i < num_clients; i++) begin : g_client
		logic [num_banks-1:0] gnt_col; // this client's column of the grant matrix
		logic [num_banks-1:0] req_col;

		for (genvar b = 0; b < num_banks; b++) begin : g_bank
			assign gnt_col[b] = gnt[b][i];
			assign req[b][i]  = req_col[b];
		end

		client_req_ctrl u_client_req_ctrl (
			.clk        (clk),
			.rst_n      (rst_n),
			.read_req   (read_req[i]),
			.read_addr  (read_addr[i]),
			.read_size  (read_size[i]),
			.write_req  (write_req[i]),
			.write_addr (write_addr[i]),
			.write_size (write_size[i]),
			.write_data (write_data[i]),
			.gnt_col    (gnt_col),
			.bank_rdata (bank_rdata),
			.req_col    (req_col),
			.read_valid (read_valid[i]),
			.read_data  (read_data[i]),
			.write_ack  (write_ack[i]),
			.bank_port  (bank_if[i])
		);
	end

	// ------------------------------------------------------------------------
	// bank side, turns the grants into sram commands
	// ------------------------------------------------------------------------
	bank_port_mux #(
		.num_clients (num_clients)
	) u_bank_port_mux (
		.gnt          (gnt),
		.clients      (bank_if),
		.bank_cs      (bank_cs),
		.bank_read    (bank_read),
		.bank_write   (bank_write),
		.bank_addr    (bank_addr),
		.bank_wdata   (bank_wdata),
		.bank_mask_en (bank_mask_en),
		.bank_mask    (bank_mask)
	);

endmodule

//--- source/bank_port_mux.sv
`timescale 1ns/1ps

module bank_port_mux
	import mem_ctrl_pkg::*;
#(
	parameter int num_clients = 4
) (
	input  logic [num_banks-1:0][num_clients-1:0] gnt, // gnt[bank][client]
	client_bank_if.mux                            clients [num_clients],
	output logic [num_banks-1:0]                  bank_cs,
	output logic [num_banks-1:0]                  bank_read,
	output logic [num_banks-1:0]                  bank_write,
	output mem_addr_t [num_banks-1:0]             bank_addr,
	output line_t [num_banks-1:0]                 bank_wdata,
	output logic [num_banks-1:0]                  bank_mask_en,
	output mask_t [num_banks-1:0]                 bank_mask
);

	// ------------------------------------------------------------------------
	// flatten the interface array so the bank loop can index it freely
	// ------------------------------------------------------------------------
	bank_id_t  c_first_bank   [num_clients];
	mem_addr_t c_first_addr   [num_clients];
	mem_addr_t c_second_addr  [num_clients];
	line_t     c_first_wdata  [num_clients];
	line_t     c_second_wdata [num_clients];
	mask_t     c_first_mask   [num_clients];
	mask_t     c_second_mask  [num_clients];
	logic      c_is_write     [num_clients];

	for (genvar j = 0; j < num_clients; j++) begin : g_client
		assign c_first_bank[j]   = clients[j].first_bank;
		assign c_first_addr[j]   = clients[j].first_addr;
		assign c_second_addr[j]  = clients[j].second_addr;
		assign c_first_wdata[j]  = clients[j].first_wdata;
		assign c_second_wdata[j] = clients[j].second_wdata;
		assign c_first_mask[j]   = clients[j].first_mask;
		assign c_second_mask[j]  = clients[j].second_mask;
		assign c_is_write[j]     = clients[j].is_write;
	end

	// ------------------------------------------------------------------------
	// per-bank command, taken from the one client that holds the grant
	// ------------------------------------------------------------------------
	always_comb begin
		logic  hit_first; // granted bank is the client's first line
		mask_t sel_mask;

		bank_cs      = '0;
		bank_read    = '0;
		bank_write   = '0;
		bank_addr    = '0;
		bank_wdata   = '0;
		bank_mask_en = '0;
		bank_mask    = '0;
		hit_first    = 1'b0;
		sel_mask     = '0;
		for (int b = 0; b < num_banks; b++) begin
			for (int j = 0; j < num_clients; j++) begin
				if (gnt[b][j]) begin // the arbiter gives each bank to one client at most
					hit_first     = (bank_id_t'(b) == c_first_bank[j]);
					sel_mask      = hit_first ? c_first_mask[j] : c_second_mask[j];
					bank_cs[b]    = 1'b1;
					bank_read[b]  = !c_is_write[j];
					bank_write[b] = c_is_write[j];
					bank_addr[b]  = hit_first ? c_first_addr[j] : c_second_addr[j];
					bank_wdata[b] = hit_first ? c_first_wdata[j] : c_second_wdata[j];
					bank_mask[b]  = sel_mask;
					bank_mask_en[b] = c_is_write[j] && !(&sel_mask); // full line needs no mask
				end
			end
		end
	end

endmodule

//--- source/client_req_ctrl.sv
`timescale 1ns/1ps

module client_req_ctrl
	import mem_ctrl_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	// read request, a level held with its address and size until read_valid
	input  logic                  read_req,
	input  mem_addr_t             read_addr,
	input  logic [size_w-1:0]     read_size,
	// write request, held with address, size and data until write_ack
	input  logic                  write_req,
	input  mem_addr_t             write_addr,
	input  logic [size_w-1:0]     write_size,
	input  line_t                 write_data,
	// arbiter and sram side
	input  logic [num_banks-1:0]  gnt_col,    // grants to this client, one per bank
	input  line_t [num_banks-1:0] bank_rdata, // lines from the srams, a cycle after gnt
	output logic [num_banks-1:0]  req_col,    // bank requests of this client
	// responses
	output logic                  read_valid,
	output line_t                 read_data,
	output logic                  write_ack,
	// per-line commands for the bank multiplexer
	client_bank_if.ctrl           bank_port
);

	// ------------------------------------------------------------------------
	// declarations
	// ------------------------------------------------------------------------
	ctrl_state_e            state;
	op_e                    op_q;        // operation taken in st_idle
	mem_addr_t              addr_q;      // start byte address of the request
	logic [size_w-1:0]      size_q;      // request size in bytes
	logic                   span_q;      // request reaches into a second line

	logic                   take_read;   // read side wins when both are pending
	mem_addr_t              start_addr;
	logic [size_w-1:0]      start_size;
	logic                   start_span;

	mem_addr_t              second_addr; // first byte of the following line
	bank_id_t               first_bank;
	bank_id_t               second_bank;
	logic [7:0]             byte_shift;  // start byte counted in bits
	logic [8:0]             tail_shift;  // bits left in the first line
	logic [8:0]             size_bits;
	mask_t                  size_mask;   // size bytes of ones starting at bit 0

	logic                   first_done;  // first line granted earlier
	logic                   second_done; // second line granted earlier
	logic                   gnt_first;
	logic                   gnt_second;
	logic                   all_granted;

	logic                   rd_first_pend;  // first line arrives on bank_rdata now
	logic                   rd_second_pend; // second line arrives on bank_rdata now
	line_t                  rd_buf_lo;
	line_t                  rd_buf_hi;
	line_t                  rd_lo;
	line_t                  rd_hi;
	logic [2*line_bits-1:0] rd_pair;

	// ------------------------------------------------------------------------
	// request selection
	// ------------------------------------------------------------------------
	assign take_read  = read_req; // a pending read always goes before a write
	assign start_addr = take_read ? read_addr : write_addr;
	assign start_size = take_read ? read_size : write_size;
	// two lines are touched once the last byte passes the end of the first line
	assign start_span = ({2'b00, start_addr[4:0]} + {1'b0, start_size}) > 7'(line_bytes);

	// FSM, the request is taken at one edge and the answer comes in st_respond
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= st_idle;
			op_q   <= op_read;
			span_q <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (read_req || write_req) begin
						state  <= st_wait_gnt;
						op_q   <= take_read ? op_read : op_write;
						span_q <= start_span;
					end
				end
				st_wait_gnt: begin
					if (all_granted)
						state <= st_respond; // the last grant is this cycle
				end
				st_respond: begin
					state <= st_idle; // a single pulse cycle
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// address and size only matter from st_wait_gnt on
	always_ff @(posedge clk) begin
		if (state == st_idle) begin
			addr_q <= start_addr;
			size_q <= start_size;
		end
	end

	assign second_addr = addr_q + mem_addr_t'(line_bytes);
	assign first_bank  = bank_of(addr_q);
	assign second_bank = bank_of(second_addr); // may cross into the next region

	// ------------------------------------------------------------------------
	// bank requests and grant tracking
	// ------------------------------------------------------------------------
	assign gnt_first   = (state == st_wait_gnt) && gnt_col[first_bank];
	assign gnt_second  = (state == st_wait_gnt) && span_q && gnt_col[second_bank];
	assign all_granted = (first_done || gnt_first) && (!span_q || second_done || gnt_second);

	// the two grants may land together or in any order
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			first_done     <= 1'b0;
			second_done    <= 1'b0;
			rd_first_pend  <= 1'b0;
			rd_second_pend <= 1'b0;
		end else begin
			if (state == st_idle) begin
				first_done  <= 1'b0;
				second_done <= 1'b0;
			end else begin
				first_done  <= first_done | gnt_first;
				second_done <= second_done | gnt_second;
			end
			rd_first_pend  <= gnt_first && (op_q == op_read);
			rd_second_pend <= gnt_second && (op_q == op_read);
		end
	end

	// requests come from registered flags only, so no path runs from gnt to req
	always_comb begin
		req_col = '0;
		if (state == st_wait_gnt) begin
			req_col[first_bank] = !first_done;
			if (span_q)
				req_col[second_bank] = !second_done; // never the same bank as the first
		end
	end

	// ------------------------------------------------------------------------
	// write alignment
	// ------------------------------------------------------------------------
	assign byte_shift = {addr_q[4:0], 3'b000};
	assign tail_shift = 9'(line_bits) - {1'b0, byte_shift}; // 256 when aligned, clears all
	assign size_bits  = {size_q, 3'b000};
	assign size_mask  = ~(mask_t'('1) << size_bits);

	assign bank_port.first_bank   = first_bank;
	assign bank_port.first_addr   = sram_addr(addr_q);
	assign bank_port.second_addr  = sram_addr(second_addr);
	assign bank_port.first_wdata  = write_data << byte_shift; // data stays stable until ack
	assign bank_port.second_wdata = write_data >> tail_shift; // the bytes that did not fit
	// masks move exactly like the data, so they cover only the written bytes
	assign bank_port.first_mask   = size_mask << byte_shift;
	assign bank_port.second_mask  = size_mask >> tail_shift;
	assign bank_port.is_write     = (op_q == op_write);

	// ------------------------------------------------------------------------
	// read assembly
	// ------------------------------------------------------------------------

	// a line that came back early is parked until the other one shows up
	always_ff @(posedge clk) begin
		if (rd_first_pend)
			rd_buf_lo <= bank_rdata[first_bank];
		if (rd_second_pend)
			rd_buf_hi <= bank_rdata[second_bank];
	end

	// in st_respond the last granted line is still on bank_rdata, take it live
	assign rd_lo = rd_first_pend ? bank_rdata[first_bank] : rd_buf_lo;
	assign rd_hi = rd_second_pend ? bank_rdata[second_bank] : rd_buf_hi;

	assign rd_pair   = {rd_hi, rd_lo} >> byte_shift; // start byte lands on byte zero
	assign read_data = rd_pair[line_bits-1:0];

	assign read_valid = (state == st_respond) && (op_q == op_read);
	assign write_ack  = (state == st_respond) && (op_q == op_write);

endmodule

//--- source/client_bank_if.sv
`timescale 1ns/1ps

// one client's view of the banks, written by its controller and read by the
// bank multiplexer whenever the arbiter grants that client a bank
interface client_bank_if
	import mem_ctrl_pkg::*;
();

	bank_id_t  first_bank;   // bank of the line holding the start byte
	mem_addr_t first_addr;   // already in sram order
	mem_addr_t second_addr;  // start address plus one line, sram order
	line_t     first_wdata;  // write data moved to its byte lane in line one
	line_t     second_wdata; // bytes that spill into the next line
	mask_t     first_mask;   // bit enables for the first line
	mask_t     second_mask;  // bit enables for the second line
	logic      is_write;     // command is a write, otherwise a read

	modport ctrl (
		output first_bank,
		output first_addr, second_addr,
		output first_wdata, second_wdata,
		output first_mask, second_mask,
		output is_write
	);

	modport mux (
		input first_bank,
		input first_addr, second_addr,
		input first_wdata, second_wdata,
		input first_mask, second_mask,
		input is_write
	);

endinterface

//--- source/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

	// ------------------------------------------------------------------------
	// address map and widths
	// ------------------------------------------------------------------------
	localparam int addr_w     = 19; // byte address over all banks
	localparam int line_bytes = 32; // one sram line, also the largest request
	localparam int line_bits  = line_bytes * 8;
	localparam int size_w     = 6;  // request size, 1 to 32 bytes
	localparam int num_banks  = 16; // 8 regions, each an even and an odd bank
	localparam int bank_w     = 4;

	// the address splits as region [18:16], row [15:6], bank bit [5], byte [4:0]
	// so consecutive lines alternate between the two banks of a region

	// ------------------------------------------------------------------------
	// types
	// ------------------------------------------------------------------------
	typedef logic [addr_w-1:0]    mem_addr_t;
	typedef logic [line_bits-1:0] line_t;
	typedef logic [bank_w-1:0]    bank_id_t;
	typedef logic [line_bits-1:0] mask_t; // one enable per data bit

	typedef enum logic {
		op_read,
		op_write
	} op_e;

	// client FSM, one pass per request
	typedef enum logic [1:0] {
		st_idle,     // waiting for read_req or write_req
		st_wait_gnt, // bank requests raised, collecting grants
		st_respond   // one cycle of read_valid or write_ack
	} ctrl_state_e;

	// ------------------------------------------------------------------------
	// address helpers
	// ------------------------------------------------------------------------

	// bank that holds the line of a byte address
	function automatic bank_id_t bank_of(input mem_addr_t addr);
		return {addr[18:16], addr[5]};
	endfunction

	// address as the sram sees it: region and bank bit on top, then row and byte
	function automatic mem_addr_t sram_addr(input mem_addr_t addr);
		return {addr[18:16], addr[5], addr[15:6], addr[4:0]};
	endfunction

endpackage
